//--- verilog/fadd_config.svh
/*
 * fadd scalar compare datapath configuration
 * widths, function-word bit positions and compare codes
 */
`ifndef FADD_CONFIG_SVH
`define FADD_CONFIG_SVH

`default_nettype none

// operand and function word widths
`define FADD_XLEN     64
`define FADD_FUNC_W   20

// function word bit positions
`define FADD_FUNC_ADD 12
`define FADD_FUNC_SUB 11
`define FADD_FUNC_CMP 10
`define FADD_FUNC_MAX 9
`define FADD_FUNC_MIN 8
`define FADD_FUNC_SGL 15
`define FADD_FUNC_DBL 16
`define FADD_FUNC_SIG 4

// compare codes in func[3:0]
`define FADD_CMP_FEQ  4'b0010
`define FADD_CMP_FLT  4'b0100
`define FADD_CMP_FLE  4'b0110
`define FADD_CMP_FNE  4'b1000

`default_nettype wire

`endif

//--- verilog/fadd_fmt_pkg.sv
/*
 * fadd format package
 * format enum, single/double operand views and operand class
 */
`include "fadd_config.svh"
`default_nettype none

package fadd_fmt_pkg;

  typedef enum logic [1:0] {
    fmt_none   = 2'd0,
    fmt_single = 2'd1,
    fmt_double = 2'd2
  } fadd_fmt_e;

  // ieee double layout
  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] frac;
  } fadd_dbl_t;

  // single sits in the low word, upper bits ignored
  typedef struct packed {
    logic [`FADD_XLEN-33:0] unused;
    logic                   sign;
    logic [7:0]             exp;
    logic [22:0]            frac;
  } fadd_sgl_t;

  typedef union packed {
    fadd_dbl_t dbl;
    fadd_sgl_t sgl;
  } fadd_operand_u;

  typedef struct packed {
    logic snan;
    logic qnan;
    logic inf;
    logic zero;
  } fadd_class_t;

endpackage

`default_nettype wire

//--- verilog/fadd_op_pkg.sv
/*
 * fadd operation package
 * compare kind and the decoded operation carried into ex2
 */
`default_nettype none

package fadd_op_pkg;

  import fadd_fmt_pkg::*;

  typedef enum logic [2:0] {
    cmp_none = 3'd0,
    cmp_feq  = 3'd1,
    cmp_flt  = 3'd2,
    cmp_fle  = 3'd3,
    cmp_fne  = 3'd4
  } fadd_cmp_e;

  // decoded operation, one flag per function
  typedef struct packed {
    logic      add;
    logic      sub;
    logic      cmp;
    logic      max;
    logic      min;
    // raise invalid on qnan too, compare only
    logic      signal;
    fadd_cmp_e cmp_kind;
    fadd_fmt_e fmt;
  } fadd_op_t;

endpackage

`default_nettype wire

//--- verilog/fadd_src_if.sv
/*
 * fadd source operand interface
 * one classified ex2 operand from a classifier to the compare unit
 */
`include "fadd_config.svh"
`default_nettype none
`timescale 1ns/1ps

interface fadd_src_if;

  // operand value, single already zero-extended
  logic [`FADD_XLEN-1:0] value;

  // operand class
  logic snan;
  logic qnan;
  logic inf;
  logic zero;

  modport prod (
    output value, snan, qnan, inf, zero
  );

  modport cons (
    input value, snan, qnan, inf, zero
  );

endinterface

`default_nettype wire

//--- verilog/fadd_ex1_decode.sv
/*
 * fadd ex1 function decode
 * splits the function word into operation flags, compare kind and
 * format, and registers the operation into ex2 on issue
 */
`include "fadd_config.svh"
`default_nettype none
`timescale 1ns/1ps

module fadd_ex1_decode
  import fadd_fmt_pkg::*;
  import fadd_op_pkg::*;
(
  input  logic                    fadd_ex1_pipe_clk,
  input  logic                    rst_n,
  input  logic                    in_vld,
  input  logic [`FADD_FUNC_W-1:0] func,
  output fadd_op_t                op_ex2,
  output logic                    vld_ex2,
  output fadd_fmt_e               fmt_ex1
);

  fadd_op_t  op_ex1;
  fadd_cmp_e cmp_kind_ex1;

  // ==========================================================================
  // ex1 decode
  // ==========================================================================

  // compare kind only meaningful with the cmp bit
  always_comb begin
    case (func[3:0])
      `FADD_CMP_FEQ: cmp_kind_ex1 = cmp_feq;
      `FADD_CMP_FLT: cmp_kind_ex1 = cmp_flt;
      `FADD_CMP_FLE: cmp_kind_ex1 = cmp_fle;
      `FADD_CMP_FNE: cmp_kind_ex1 = cmp_fne;
      default:       cmp_kind_ex1 = cmp_none;
    endcase
    if (!func[`FADD_FUNC_CMP]) begin
      cmp_kind_ex1 = cmp_none;
    end
  end

  // double wins if both format bits are set
  always_comb begin
    if (func[`FADD_FUNC_DBL]) begin
      fmt_ex1 = fmt_double;
    end else if (func[`FADD_FUNC_SGL]) begin
      fmt_ex1 = fmt_single;
    end else begin
      fmt_ex1 = fmt_none;
    end
  end

  always_comb begin
    op_ex1.add      = func[`FADD_FUNC_ADD];
    op_ex1.sub      = func[`FADD_FUNC_SUB];
    op_ex1.cmp      = func[`FADD_FUNC_CMP];
    op_ex1.max      = func[`FADD_FUNC_MAX];
    op_ex1.min      = func[`FADD_FUNC_MIN];
    op_ex1.signal   = func[`FADD_FUNC_CMP] & func[`FADD_FUNC_SIG];
    op_ex1.cmp_kind = cmp_kind_ex1;
    op_ex1.fmt      = fmt_ex1;
  end

  // ==========================================================================
  // ex2 operation register
  // ==========================================================================

  always_ff @(posedge fadd_ex1_pipe_clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_ex2 <= 1'b0;
    end else begin
      vld_ex2 <= in_vld;
    end
  end

  always_ff @(posedge fadd_ex1_pipe_clk) begin
    if (in_vld) begin
      op_ex2.add <= op_ex1.add;
      op_ex2.sub <= op_ex1.sub;
      op_ex2.cmp <= op_ex1.cmp;
      op_ex2.max <= op_ex1.max;
      op_ex2.min <= op_ex1.min;
      op_ex2.fmt <= op_ex1.fmt;
      // compare fields only move on compare issues
      if (op_ex1.cmp) begin
        op_ex2.signal   <= op_ex1.signal;
        op_ex2.cmp_kind <= op_ex1.cmp_kind;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/fadd_src_classify.sv
/*
 * fadd source operand classifier
 * views one source as single or double, flags snan/qnan/inf/zero
 * and registers value and class into ex2
 */
`include "fadd_config.svh"
`default_nettype none
`timescale 1ns/1ps

module fadd_src_classify
  import fadd_fmt_pkg::*;
(
  input  logic                  fadd_ex1_pipe_clk,
  input  logic [`FADD_XLEN-1:0] src,
  input  fadd_fmt_e             fmt_ex1,
  input  logic                  in_vld,
  fadd_src_if.prod              cls
);

  fadd_operand_u         opnd;
  fadd_class_t           cls_ex1;
  logic [`FADD_XLEN-1:0] value_ex1;
  logic                  exp_ones;
  logic                  exp_zero;
  logic                  frac_zero;
  logic                  frac_msb;

  assign opnd = src;

  // field extraction per view, fmt_none falls back to the single view
  always_comb begin
    if (fmt_ex1 == fmt_double) begin
      exp_ones  = &opnd.dbl.exp;
      exp_zero  = ~|opnd.dbl.exp;
      frac_zero = ~|opnd.dbl.frac;
      frac_msb  = opnd.dbl.frac[51];
      value_ex1 = opnd;
    end else begin
      exp_ones  = &opnd.sgl.exp;
      exp_zero  = ~|opnd.sgl.exp;
      frac_zero = ~|opnd.sgl.frac;
      frac_msb  = opnd.sgl.frac[22];
      value_ex1 = {{(`FADD_XLEN-32){1'b0}}, opnd.sgl.sign, opnd.sgl.exp, opnd.sgl.frac};
    end
  end

  // quiet bit is the top fraction bit
  always_comb begin
    cls_ex1.snan = exp_ones & ~frac_zero & ~frac_msb;
    cls_ex1.qnan = exp_ones & ~frac_zero & frac_msb;
    cls_ex1.inf  = exp_ones & frac_zero;
    cls_ex1.zero = exp_zero & frac_zero;
  end

  always_ff @(posedge fadd_ex1_pipe_clk) begin
    if (in_vld) begin
      cls.value <= value_ex1;
      cls.snan  <= cls_ex1.snan;
      cls.qnan  <= cls_ex1.qnan;
      cls.inf   <= cls_ex1.inf;
      cls.zero  <= cls_ex1.zero;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fadd_cmp_sel.sv
/*
 * fadd compare and max/min unit
 * ex2 compare and max/min with nan and signed-zero handling,
 * ex3 result stage, ex4 stage for double max/min
 */
`include "fadd_config.svh"
`default_nettype none
`timescale 1ns/1ps

module fadd_cmp_sel
  import fadd_fmt_pkg::*;
  import fadd_op_pkg::*;
(
  input  logic                  fadd_ex1_pipe_clk,
  input  logic                  rst_n,
  input  fadd_op_t              op_ex2,
  input  logic                  vld_ex2,
  fadd_src_if.cons              a,
  fadd_src_if.cons              b,
  output logic                  ex3_vld,
  output logic                  ex3_gpr_result,
  output logic [`FADD_XLEN-1:0] ex3_fpr_result,
  output logic [4:0]            ex3_fflags,
  output logic                  ex4_vld,
  output logic [`FADD_XLEN-1:0] ex4_fpr_result,
  output logic [4:0]            ex4_fflags
);

  localparam logic [`FADD_XLEN-1:0] cnan_dbl = 64'h7ff8_0000_0000_0000;
  localparam logic [`FADD_XLEN-1:0] cnan_sgl = 64'h0000_0000_7fc0_0000;

  fadd_operand_u         a_u;
  fadd_operand_u         b_u;
  logic                  dbl_ex2;
  logic                  sign_a;
  logic                  sign_b;
  logic [62:0]           mag_a;
  logic [62:0]           mag_b;
  logic                  a_nan;
  logic                  b_nan;
  logic                  any_snan;
  logic                  any_qnan;
  logic                  both_zero;
  logic                  eq_ex2;
  logic                  lt_ex2;
  logic                  cmp_res_ex2;
  logic                  cmp_nv_ex2;
  logic [`FADD_XLEN-1:0] sel_res_ex2;
  logic                  sel_ex2;
  logic                  res_vld_ex2;
  logic                  ex3_go;
  logic                  ex4_go;
  logic                  nv_ex2;
  logic                  nv_ex3;
  logic                  dbl_ex3;
  logic                  nv_ex4;

  // ==========================================================================
  // ex2 operand fields
  // ==========================================================================

  assign a_u     = a.value;
  assign b_u     = b.value;
  assign dbl_ex2 = (op_ex2.fmt == fmt_double);

  assign sign_a = dbl_ex2 ? a_u.dbl.sign : a_u.sgl.sign;
  assign sign_b = dbl_ex2 ? b_u.dbl.sign : b_u.sgl.sign;
  assign mag_a  = dbl_ex2 ? {a_u.dbl.exp, a_u.dbl.frac} : {32'b0, a_u.sgl.exp, a_u.sgl.frac};
  assign mag_b  = dbl_ex2 ? {b_u.dbl.exp, b_u.dbl.frac} : {32'b0, b_u.sgl.exp, b_u.sgl.frac};

  assign a_nan     = a.snan | a.qnan;
  assign b_nan     = b.snan | b.qnan;
  assign any_snan  = a.snan | b.snan;
  assign any_qnan  = a.qnan | b.qnan;
  assign both_zero = a.zero & b.zero;

  // ==========================================================================
  // ex2 compare
  // ==========================================================================

  // +0 and -0 are equal
  assign eq_ex2 = ~(a_nan | b_nan) & (both_zero | (sign_a == sign_b && mag_a == mag_b));

  // sign-magnitude order, not valid for nans
  always_comb begin
    if (both_zero) begin
      lt_ex2 = 1'b0;
    end else if (sign_a != sign_b) begin
      lt_ex2 = sign_a;
    end else if (sign_a) begin
      lt_ex2 = mag_a > mag_b;
    end else begin
      lt_ex2 = mag_a < mag_b;
    end
  end

  always_comb begin
    case (op_ex2.cmp_kind)
      cmp_feq: cmp_res_ex2 = eq_ex2;
      cmp_flt: cmp_res_ex2 = lt_ex2 & ~(a_nan | b_nan);
      cmp_fle: cmp_res_ex2 = (lt_ex2 | eq_ex2) & ~(a_nan | b_nan);
      cmp_fne: cmp_res_ex2 = ~eq_ex2;
      default: cmp_res_ex2 = 1'b0;
    endcase
  end

  // qnan only counts for ordered compares or the signalling variant
  assign cmp_nv_ex2 = any_snan
                    | (any_qnan & ((op_ex2.cmp_kind == cmp_flt)
                                 | (op_ex2.cmp_kind == cmp_fle)
                                 | op_ex2.signal));

  // ==========================================================================
  // ex2 max/min
  // ==========================================================================

  always_comb begin
    if (a_nan && b_nan) begin
      sel_res_ex2 = dbl_ex2 ? cnan_dbl : cnan_sgl;
    end else if (a_nan) begin
      sel_res_ex2 = b.value;
    end else if (b_nan) begin
      sel_res_ex2 = a.value;
    end else if (both_zero) begin
      // min takes the negative zero, max the positive one
      sel_res_ex2 = (op_ex2.min == sign_a) ? a.value : b.value;
    end else begin
      sel_res_ex2 = (op_ex2.min == lt_ex2) ? a.value : b.value;
    end
  end

  // ==========================================================================
  // stage control
  // ==========================================================================

  // add/sub results come from the external adder
  assign sel_ex2     = op_ex2.max | op_ex2.min;
  assign res_vld_ex2 = vld_ex2 & ~(op_ex2.add | op_ex2.sub) & (op_ex2.cmp | sel_ex2);
  assign ex3_go      = res_vld_ex2 & (op_ex2.cmp | ~dbl_ex2);
  assign ex4_go      = res_vld_ex2 & ~op_ex2.cmp & dbl_ex2;
  assign nv_ex2      = op_ex2.cmp ? cmp_nv_ex2 : any_snan;

  always_ff @(posedge fadd_ex1_pipe_clk or negedge rst_n) begin
    if (!rst_n) begin
      ex3_vld <= 1'b0;
      dbl_ex3 <= 1'b0;
      nv_ex3  <= 1'b0;
      ex4_vld <= 1'b0;
      nv_ex4  <= 1'b0;
    end else begin
      ex3_vld <= ex3_go;
      dbl_ex3 <= ex4_go;
      if (ex3_go || ex4_go) begin
        nv_ex3 <= nv_ex2;
      end
      ex4_vld <= dbl_ex3;
      if (dbl_ex3) begin
        nv_ex4 <= nv_ex3;
      end
    end
  end

  // double max/min shares the ex3 register on its way to ex4
  always_ff @(posedge fadd_ex1_pipe_clk) begin
    if (ex3_go || ex4_go) begin
      ex3_fpr_result <= op_ex2.cmp ? {{(`FADD_XLEN-1){1'b0}}, cmp_res_ex2} : sel_res_ex2;
      ex3_gpr_result <= op_ex2.cmp & cmp_res_ex2;
    end
    if (dbl_ex3) begin
      ex4_fpr_result <= ex3_fpr_result;
    end
  end

  // only the invalid flag is ever raised here
  assign ex3_fflags = {nv_ex3, 4'b0};
  assign ex4_fflags = {nv_ex4, 4'b0};

endmodule

`default_nettype wire

//--- verilog/fadd_scalar_dp.sv
/*
 * fadd scalar compare and max/min datapath top
 * decode, one classifier per source and the compare unit
 */
`include "fadd_config.svh"
`default_nettype none
`timescale 1ns/1ps

module fadd_scalar_dp
  import fadd_fmt_pkg::*;
  import fadd_op_pkg::*;
(
  input  logic                    fadd_ex1_pipe_clk,
  input  logic                    rst_n,
  input  logic                    in_vld,
  input  logic [`FADD_FUNC_W-1:0] func,
  input  logic [`FADD_XLEN-1:0]   src0,
  input  logic [`FADD_XLEN-1:0]   src1,
  output logic                    ex3_vld,
  output logic                    ex3_gpr_result,
  output logic [`FADD_XLEN-1:0]   ex3_fpr_result,
  output logic [4:0]              ex3_fflags,
  output logic                    ex4_vld,
  output logic [`FADD_XLEN-1:0]   ex4_fpr_result,
  output logic [4:0]              ex4_fflags
);

  fadd_op_t              op_ex2;
  logic                  vld_ex2;
  fadd_fmt_e             fmt_ex1;
  logic [`FADD_XLEN-1:0] src_ex1 [2];

  fadd_src_if src_if [2] ();

  assign src_ex1[0] = src0;
  assign src_ex1[1] = src1;

  fadd_ex1_decode u_ex1_decode (
    .fadd_ex1_pipe_clk (fadd_ex1_pipe_clk),
    .rst_n             (rst_n),
    .in_vld            (in_vld),
    .func              (func),
    .op_ex2            (op_ex2),
    .vld_ex2           (vld_ex2),
    .fmt_ex1           (fmt_ex1)
  );

  // one classifier per source operand
  for (genvar i = 0; i < 2; i++) begin : g_src
    fadd_src_classify u_src_classify (
      .fadd_ex1_pipe_clk (fadd_ex1_pipe_clk),
      .src               (src_ex1[i]),
      .fmt_ex1           (fmt_ex1),
      .in_vld            (in_vld),
      .cls               (src_if[i])
    );
  end

  fadd_cmp_sel u_cmp_sel (
    .fadd_ex1_pipe_clk (fadd_ex1_pipe_clk),
    .rst_n             (rst_n),
    .op_ex2            (op_ex2),
    .vld_ex2           (vld_ex2),
    .a                 (src_if[0]),
    .b                 (src_if[1]),
    .ex3_vld           (ex3_vld),
    .ex3_gpr_result    (ex3_gpr_result),
    .ex3_fpr_result    (ex3_fpr_result),
    .ex3_fflags        (ex3_fflags),
    .ex4_vld           (ex4_vld),
    .ex4_fpr_result    (ex4_fpr_result),
    .ex4_fflags        (ex4_fflags)
  );

endmodule

`default_nettype wire

//--- verification/fadd_scalar_dp_checker.sv
/*
 * fadd scalar datapath checker
 * tracks issues in a shift history and checks result latency,
 * idle outputs after reset and the result word layout
 */
`include "fadd_config.svh"
`default_nettype none
`timescale 1ns/1ps

module fadd_scalar_dp_checker (
  input logic                    fadd_ex1_pipe_clk,
  input logic                    rst_n,
  input logic                    in_vld,
  input logic [`FADD_FUNC_W-1:0] func,
  input logic                    ex3_vld,
  input logic                    ex3_gpr_result,
  input logic [`FADD_XLEN-1:0]   ex3_fpr_result,
  input logic [4:0]              ex3_fflags,
  input logic                    ex4_vld,
  input logic [4:0]              ex4_fflags
);

  logic        iss_sel;
  logic        iss_ex3;
  logic        iss_ex4;
  logic [1:0]  ex3_hist;
  logic [1:0]  cmp_hist;
  logic [1:0]  sgl_hist;
  logic [2:0]  ex4_hist;
  logic        seen_issue;
  int unsigned err_cnt = 0;

  // ==========================================================================
  // issue history
  // ==========================================================================

  // add/sub issues never produce a result here
  assign iss_sel = (func[`FADD_FUNC_MAX] | func[`FADD_FUNC_MIN])
                 & ~func[`FADD_FUNC_ADD] & ~func[`FADD_FUNC_SUB];
  assign iss_ex3 = in_vld & ((func[`FADD_FUNC_CMP] & ~func[`FADD_FUNC_ADD]
                 & ~func[`FADD_FUNC_SUB]) | (iss_sel & ~func[`FADD_FUNC_DBL]));
  assign iss_ex4 = in_vld & iss_sel & ~func[`FADD_FUNC_CMP] & func[`FADD_FUNC_DBL];

  always_ff @(posedge fadd_ex1_pipe_clk or negedge rst_n) begin
    if (!rst_n) begin
      ex3_hist   <= '0;
      cmp_hist   <= '0;
      sgl_hist   <= '0;
      ex4_hist   <= '0;
      seen_issue <= 1'b0;
    end else begin
      ex3_hist   <= {ex3_hist[0], iss_ex3};
      cmp_hist   <= {cmp_hist[0], iss_ex3 & func[`FADD_FUNC_CMP]};
      sgl_hist   <= {sgl_hist[0], iss_ex3 & ~func[`FADD_FUNC_DBL]};
      ex4_hist   <= {ex4_hist[1:0], iss_ex4};
      seen_issue <= seen_issue | in_vld;
    end
  end

  // ==========================================================================
  // assertions
  // ==========================================================================

  a_ex3_latency: assert property (@(posedge fadd_ex1_pipe_clk) disable iff (!rst_n)
    ex3_vld == ex3_hist[1])
    else begin
      err_cnt++;
      $error("ex3_vld does not match an issue two edges earlier");
    end

  a_ex4_latency: assert property (@(posedge fadd_ex1_pipe_clk) disable iff (!rst_n)
    ex4_vld == ex4_hist[2])
    else begin
      err_cnt++;
      $error("ex4_vld does not match a double max/min issue three edges earlier");
    end

  a_idle: assert property (@(posedge fadd_ex1_pipe_clk) disable iff (!rst_n)
    !seen_issue |-> (!ex3_vld && !ex4_vld && ex3_fflags == 5'b0 && ex4_fflags == 5'b0))
    else begin
      err_cnt++;
      $error("outputs active before the first issue");
    end

  // only the invalid flag may be set
  a_flags: assert property (@(posedge fadd_ex1_pipe_clk) disable iff (!rst_n)
    (!ex3_vld || ex3_fflags[3:0] == 4'b0) && (!ex4_vld || ex4_fflags[3:0] == 4'b0))
    else begin
      err_cnt++;
      $error("fflags bits other than invalid are set");
    end

  a_single_upper: assert property (@(posedge fadd_ex1_pipe_clk) disable iff (!rst_n)
    (ex3_vld && sgl_hist[1]) |-> ex3_fpr_result[63:32] == 32'b0)
    else begin
      err_cnt++;
      $error("single result has nonzero upper word");
    end

  a_cmp_word: assert property (@(posedge fadd_ex1_pipe_clk) disable iff (!rst_n)
    (ex3_vld && cmp_hist[1]) |-> (ex3_fpr_result[63:1] == 63'b0
                                  && ex3_gpr_result == ex3_fpr_result[0]))
    else begin
      err_cnt++;
      $error("compare result differs between gpr and fpr outputs");
    end

endmodule

bind fadd_scalar_dp fadd_scalar_dp_checker u_checker (
  .fadd_ex1_pipe_clk (fadd_ex1_pipe_clk),
  .rst_n             (rst_n),
  .in_vld            (in_vld),
  .func              (func),
  .ex3_vld           (ex3_vld),
  .ex3_gpr_result    (ex3_gpr_result),
  .ex3_fpr_result    (ex3_fpr_result),
  .ex3_fflags        (ex3_fflags),
  .ex4_vld           (ex4_vld),
  .ex4_fflags        (ex4_fflags)
);

`default_nettype wire

//--- verification/fadd_scalar_dp_tb.sv
/*
 * fadd scalar datapath testbench
 * directed and random compare and max/min operations, values checked
 * by immediate assertions, latency by the bound checker
 */
`include "fadd_config.svh"
`default_nettype none
`timescale 1ns/1ps

module fadd_scalar_dp_tb;

  logic                    fadd_ex1_pipe_clk;
  logic                    rst_n;
  logic                    in_vld;
  logic [`FADD_FUNC_W-1:0] func;
  logic [`FADD_XLEN-1:0]   src0;
  logic [`FADD_XLEN-1:0]   src1;
  logic                    ex3_vld;
  logic                    ex3_gpr_result;
  logic [`FADD_XLEN-1:0]   ex3_fpr_result;
  logic [4:0]              ex3_fflags;
  logic                    ex4_vld;
  logic [`FADD_XLEN-1:0]   ex4_fpr_result;
  logic [4:0]              ex4_fflags;

  integer      seed = 64;
  int          tests = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_checks = 0;
  int          test_errors = 0;
  int          want_ex3;
  int          want_ex4;
  int          got_ex3;
  int          got_ex4;
  logic [63:0] res_fpr;
  logic        res_gpr;
  logic        res_nv;
  logic        res_ex4;
  logic [63:0] a;
  logic [63:0] b;
  logic [3:0]  cmp_codes [4];

  fadd_scalar_dp u_fadd_scalar_dp (.*);

  initial fadd_ex1_pipe_clk = 1'b0;
  always #5 fadd_ex1_pipe_clk = ~fadd_ex1_pipe_clk;

  // ==========================================================================
  // reference helpers
  // ==========================================================================

  function automatic logic [63:0] zero_ext(input logic [63:0] x, input bit dbl);
    return dbl ? x : {32'b0, x[31:0]};
  endfunction

  function automatic bit is_nan(input logic [63:0] x, input bit dbl);
    return dbl ? (&x[62:52] && |x[51:0]) : (&x[30:23] && |x[22:0]);
  endfunction

  function automatic bit is_snan(input logic [63:0] x, input bit dbl);
    return is_nan(x, dbl) && !(dbl ? x[51] : x[22]);
  endfunction

  // signed key for non-nan values where both zeros map to 0
  function automatic logic signed [64:0] order_key(input logic [63:0] x, input bit dbl);
    logic signed [64:0] mag;
    mag = dbl ? {2'b0, x[62:0]} : {34'b0, x[30:0]};
    return (dbl ? x[63] : x[31]) ? -mag : mag;
  endfunction

  function automatic logic [`FADD_FUNC_W-1:0] make_func(input bit dbl, input bit cmp,
                                                        input bit mx, input logic [3:0] code,
                                                        input bit sig);
    logic [`FADD_FUNC_W-1:0] f;
    f = '0;
    f[`FADD_FUNC_DBL] = dbl;
    f[`FADD_FUNC_SGL] = !dbl;
    f[`FADD_FUNC_CMP] = cmp;
    f[`FADD_FUNC_MAX] = !cmp && mx;
    f[`FADD_FUNC_MIN] = !cmp && !mx;
    if (cmp) begin
      f[3:0] = code;
      f[`FADD_FUNC_SIG] = sig;
    end
    return f;
  endfunction

  // random operand that is never a nan
  function automatic logic [63:0] rand_num(input bit dbl);
    logic [63:0] x;
    x = {$random(seed), $random(seed)};
    if (is_nan(x, dbl)) begin
      x[dbl ? 62 : 30] = 1'b0;
    end
    return x;
  endfunction

  // ==========================================================================
  // operation tasks
  // ==========================================================================

  // one issue cycle, then wait for the ex3 or ex4 result
  task automatic run_op(input logic [`FADD_FUNC_W-1:0] f, input logic [63:0] x,
                        input logic [63:0] y);
    int n;
    in_vld = 1'b1;
    func = f;
    src0 = x;
    src1 = y;
    @(posedge fadd_ex1_pipe_clk);
    #1;
    in_vld = 1'b0;
    n = 0;
    while (!ex3_vld && !ex4_vld && n < 8) begin
      @(posedge fadd_ex1_pipe_clk);
      #1;
      n++;
    end
    if (!ex3_vld && !ex4_vld) begin
      $display("no result within %0d cycles of the issue, time %0t", n, $time);
      errors++;
    end
    res_ex4 = ex4_vld;
    res_fpr = ex4_vld ? ex4_fpr_result : ex3_fpr_result;
    res_gpr = ex3_gpr_result;
    res_nv  = ex4_vld ? ex4_fflags[4] : ex3_fflags[4];
  endtask

  task automatic check_cmp(input logic [3:0] code, input bit sig, input bit dbl,
                           input logic [63:0] x, input logic [63:0] y);
    bit nan;
    bit eq;
    bit lt;
    bit exp_r;
    bit exp_nv;
    nan = is_nan(x, dbl) || is_nan(y, dbl);
    eq  = !nan && order_key(x, dbl) == order_key(y, dbl);
    lt  = !nan && order_key(x, dbl) < order_key(y, dbl);
    case (code)
      `FADD_CMP_FEQ: exp_r = eq;
      `FADD_CMP_FLT: exp_r = lt;
      `FADD_CMP_FLE: exp_r = lt || eq;
      default:       exp_r = !eq;
    endcase
    exp_nv = is_snan(x, dbl) || is_snan(y, dbl)
           || (nan && (sig || code == `FADD_CMP_FLT || code == `FADD_CMP_FLE));
    run_op(make_func(dbl, 1'b1, 1'b0, code, sig), x, y);
    checks++;
    assert (res_gpr == exp_r && res_fpr == {63'b0, exp_r} && res_nv == exp_nv && !res_ex4)
      else begin
        $display("MISMATCH at %0t: cmp %b sig %b a %h b %h got %b nv %b, expected %b nv %b",
                 $time, code, sig, x, y, res_gpr, res_nv, exp_r, exp_nv);
        errors++;
      end
  endtask

  task automatic check_maxmin(input bit mx, input bit dbl, input logic [63:0] x,
                              input logic [63:0] y);
    logic [63:0]        exp_v;
    logic signed [64:0] kx;
    logic signed [64:0] ky;
    bit                 take_x;
    kx = order_key(x, dbl);
    ky = order_key(y, dbl);
    // equal keys with different bits only happen for signed zeros
    if (kx == ky) begin
      take_x = (dbl ? x[63] : x[31]) ^ mx;
    end else begin
      take_x = mx ? (kx > ky) : (kx < ky);
    end
    if (is_nan(x, dbl) && is_nan(y, dbl)) begin
      exp_v = dbl ? 64'h7ff8_0000_0000_0000 : 64'h0000_0000_7fc0_0000;
    end else if (is_nan(x, dbl)) begin
      exp_v = zero_ext(y, dbl);
    end else if (is_nan(y, dbl)) begin
      exp_v = zero_ext(x, dbl);
    end else begin
      exp_v = zero_ext(take_x ? x : y, dbl);
    end
    run_op(make_func(dbl, 1'b0, mx, 4'b0, 1'b0), x, y);
    checks++;
    assert (res_fpr == exp_v && res_nv == (is_snan(x, dbl) || is_snan(y, dbl))
            && res_ex4 == dbl)
      else begin
        $display("MISMATCH at %0t: max %b dbl %b a %h b %h got %h nv %b, expected %h",
                 $time, mx, dbl, x, y, res_fpr, res_nv, exp_v);
        errors++;
      end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("%s: %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  initial begin
    cmp_codes = '{`FADD_CMP_FEQ, `FADD_CMP_FLT, `FADD_CMP_FLE, `FADD_CMP_FNE};
    rst_n  = 1'b0;
    in_vld = 1'b0;
    func   = '0;
    src0   = '0;
    src1   = '0;
    repeat (5) @(posedge fadd_ex1_pipe_clk);
    #1;
    rst_n = 1'b1;

    repeat (3) begin
      @(posedge fadd_ex1_pipe_clk);
      #1;
      checks++;
      assert (!ex3_vld && !ex4_vld && ex3_fflags == 5'b0 && ex4_fflags == 5'b0)
        else begin
          $display("MISMATCH at %0t: outputs active after reset", $time);
          errors++;
        end
    end
    end_test("reset");

    for (int i = 0; i < 64; i++) begin
      a = rand_num(i[0]);
      b = (i % 5 == 0) ? a : rand_num(i[0]);
      check_cmp(cmp_codes[i[2:1]], i[3], i[0], a, b);
    end
    check_cmp(`FADD_CMP_FEQ, 1'b0, 1'b1, 64'h8000_0000_0000_0000, 64'h0);
    check_cmp(`FADD_CMP_FLT, 1'b0, 1'b0, 64'h0000_0000_8000_0000, 64'h0);
    check_cmp(`FADD_CMP_FLE, 1'b0, 1'b0, 64'hdead_beef_0000_0000, 64'h8000_0000);
    end_test("cmp_ordered");

    for (int k = 0; k < 8; k++) begin
      check_cmp(cmp_codes[k[1:0]], k[2], 1'b1, 64'h7ff8_0000_0000_0001,
                64'h3ff0_0000_0000_0000);
      check_cmp(cmp_codes[k[1:0]], k[2], 1'b0, 64'h3f80_0000, 64'h7fc0_0000);
    end
    check_cmp(`FADD_CMP_FEQ, 1'b0, 1'b1, 64'h7ff0_0000_0000_0001, 64'h0);
    check_cmp(`FADD_CMP_FNE, 1'b0, 1'b0, 64'h0, 64'h7f80_0001);
    end_test("cmp_nan");

    // k[0] selects max, k[1] selects double
    for (int k = 0; k < 4; k++) begin
      a = k[1] ? 64'h7ff8_0000_0000_0000 : 64'hffff_ffff_7fc0_0000;
      b = k[1] ? 64'h3ff0_0000_0000_0000 : 64'h1234_5678_3f80_0000;
      check_maxmin(k[0], k[1], a, b);
      a = k[1] ? 64'h7ff0_0000_0000_0001 : 64'h0000_0000_7f80_0001;
      check_maxmin(k[0], k[1], b, a);
      check_maxmin(k[0], k[1], 64'h7ff8_0000_7fc0_0000, a);
      b = k[1] ? 64'h8000_0000_0000_0000 : 64'h5555_0000_8000_0000;
      check_maxmin(k[0], k[1], b, 64'h0);
      check_maxmin(k[0], k[1], 64'h0, b);
    end
    end_test("maxmin_special");

    for (int i = 0; i < 32; i++) begin
      a = rand_num(i[1]);
      b = (i % 4 == 0) ? (a ^ (i[1] ? 64'h8000_0000_0000_0000 : 64'h8000_0000))
                       : rand_num(i[1]);
      check_maxmin(i[0], i[1], a, b);
    end
    end_test("maxmin_random");

    // mixed issue every cycle with pulse counts compared after the drain
    want_ex3 = 0;
    want_ex4 = 0;
    got_ex3  = 0;
    got_ex4  = 0;
    for (int i = 0; i < 16; i++) begin
      in_vld = 1'b1;
      func   = make_func(i[0], i % 3 == 0, i[1], cmp_codes[i[3:2]], 1'b0);
      src0   = rand_num(i[0]);
      src1   = rand_num(i[0]);
      if (i % 3 == 0 || !i[0]) begin
        want_ex3++;
      end else begin
        want_ex4++;
      end
      @(posedge fadd_ex1_pipe_clk);
      #1;
      got_ex3 += int'(ex3_vld);
      got_ex4 += int'(ex4_vld);
    end
    in_vld = 1'b0;
    // the ex4 path drains three edges after its issue
    repeat (4) begin
      @(posedge fadd_ex1_pipe_clk);
      #1;
      got_ex3 += int'(ex3_vld);
      got_ex4 += int'(ex4_vld);
    end
    checks++;
    assert (got_ex3 == want_ex3 && got_ex4 == want_ex4)
      else begin
        $display("MISMATCH at %0t: pulses ex3 %0d ex4 %0d, expected %0d and %0d",
                 $time, got_ex3, got_ex4, want_ex3, want_ex4);
        errors++;
      end
    end_test("back_to_back");

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests, checks,
             errors, u_fadd_scalar_dp.u_checker.err_cnt);
    if (errors == 0 && u_fadd_scalar_dp.u_checker.err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+verilog
verilog/fadd_fmt_pkg.sv
verilog/fadd_op_pkg.sv
verilog/fadd_src_if.sv
verilog/fadd_ex1_decode.sv
verilog/fadd_src_classify.sv
verilog/fadd_cmp_sel.sv
verilog/fadd_scalar_dp.sv
verification/fadd_scalar_dp_checker.sv
verification/fadd_scalar_dp_tb.sv

//--- Makefile
# Verilator build and run for the fadd scalar compare datapath

BIN := obj_dir/Vfadd_scalar_dp_tb

.PHONY: all run clean

all: run

$(BIN): all.f $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module fadd_scalar_dp_tb -f all.f

# pass only when the simulation prints the pass line
run: $(BIN)
	@out="$$(./$(BIN) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
